/* arrayControl.sv */
/*
  Stage 1. Allocation state and sizes change on the edge that registers the command,
  so a request in the next cycle already sees them. A failed check changes nothing.
*/
`timescale 1ns/100ps

module arrayControl import arrayPkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        requestValid,
  input  arrayRequest request,
  output storeCommand command
);

  logic               allocated [arrayCount];
  sizeCount           sizes     [arrayCount];
  arrayId             freeStack [arrayCount];      // Freed arrays, most recent on top
  logic [arrayBits:0] freeTop;                     // Entries on the free stack
  logic [arrayBits:0] nextUnused;                  // First array never handed out

  logic [arrayBits:0] stackTop;
  logic               fromStack;
  logic               outOfMemory;
  arrayId             allocId;
  sizeCount           currentSize;
  sizeCount           popSlot;
  logic               isAllocated;
  logic               inBounds;
  logic               isFull;
  logic               isEmpty;
  arrayError          allocError;
  arrayError          accessError;

  storeCommand        nextCommand;
  logic               sizeWrite;
  arrayId             sizeTarget;
  sizeCount           sizeValue;
  logic               doAlloc;
  logic               doFree;
  logic               doReset;

  // ------------------------------
  // Checks on the addressed array
  // ------------------------------
  always_comb begin
    currentSize = sizes[request.array];
    isAllocated = allocated[request.array];
    inBounds    = {1'b0, request.index} < currentSize;
    isFull      = currentSize == sizeCount'(arrayLength);
    isEmpty     = currentSize == '0;
    popSlot     = currentSize - 1'b1;
    stackTop    = freeTop - 1'b1;
    fromStack   = freeTop != '0;                   // Reuse before fresh arrays
    allocId     = fromStack ? freeStack[stackTop[arrayBits-1:0]] : nextUnused[arrayBits-1:0];
    outOfMemory = !fromStack && (nextUnused == (arrayBits + 1)'(arrayCount));
    allocError  = isAllocated ? errNone : errNotAllocated;
    accessError = !isAllocated ? errNotAllocated : (inBounds ? errNone : errOutOfBounds);
  end

  // ------------------------------
  // Opcode decode
  // ------------------------------
  always_comb begin
    nextCommand               = '0;
    nextCommand.valid         = requestValid;
    nextCommand.address.array = request.array;
    nextCommand.address.index = request.index;
    nextCommand.func          = fnKeep;
    nextCommand.operand       = request.operand;
    nextCommand.error         = errNone;
    sizeWrite                 = 1'b0;
    sizeTarget                = request.array;
    sizeValue                 = currentSize;
    doAlloc                   = 1'b0;
    doFree                    = 1'b0;
    doReset                   = 1'b0;

    case (request.opcode)
      opReset: begin
        nextCommand.direct = 1'b1;                 // Reports 0
        doReset            = 1'b1;
      end
      opAlloc: begin
        nextCommand.error       = outOfMemory ? errOutOfMemory : errNone;
        nextCommand.direct      = 1'b1;
        nextCommand.directValue = elementWord'(allocId);
        doAlloc                 = 1'b1;
        sizeWrite               = 1'b1;            // New array starts empty
        sizeTarget              = allocId;
        sizeValue               = '0;
      end
      opFree: begin
        nextCommand.error  = allocError;
        nextCommand.direct = 1'b1;
        doFree             = 1'b1;
      end
      opWrite: begin
        nextCommand.error       = allocError;
        nextCommand.func        = fnReplace;
        nextCommand.writeEnable = 1'b1;
        if (!inBounds) begin
          sizeWrite = 1'b1;                        // Grow to index plus one
          sizeValue = {1'b0, request.index} + 1'b1;
        end
      end
      opRead: begin
        nextCommand.error = accessError;
      end
      opSize: begin
        nextCommand.error       = allocError;
        nextCommand.direct      = 1'b1;
        nextCommand.directValue = elementWord'(currentSize);
      end
      opPush: begin
        nextCommand.error         = (allocError != errNone) ? allocError :
                                    (isFull ? errFull : errNone);
        nextCommand.address.index = currentSize[indexBits-1:0];
        nextCommand.func          = fnReplace;
        nextCommand.writeEnable   = 1'b1;
        sizeWrite                 = 1'b1;
        sizeValue                 = currentSize + 1'b1;
      end
      opPop: begin
        nextCommand.error         = (allocError != errNone) ? allocError :
                                    (isEmpty ? errEmpty : errNone);
        nextCommand.address.index = popSlot[indexBits-1:0];
        nextCommand.reportOld     = 1'b1;
        sizeWrite                 = 1'b1;
        sizeValue                 = popSlot;
      end
      opAdd, opAddAfter: begin
        nextCommand.error       = accessError;
        nextCommand.func        = fnAdd;
        nextCommand.writeEnable = 1'b1;
        nextCommand.reportOld   = request.opcode == opAddAfter;
      end
      opSubtract: begin
        nextCommand.error       = accessError;
        nextCommand.func        = fnSubtract;
        nextCommand.writeEnable = 1'b1;
      end
      opXor: begin
        nextCommand.error       = accessError;
        nextCommand.func        = fnXor;
        nextCommand.writeEnable = 1'b1;
      end
      default: begin
        nextCommand.direct = 1'b1;                 // Unused opcode, harmless 0
      end
    endcase

    // A failed check leaves state and memory alone
    if (nextCommand.error != errNone) begin
      nextCommand.writeEnable = 1'b0;
      sizeWrite               = 1'b0;
      doAlloc                 = 1'b0;
      doFree                  = 1'b0;
    end
  end

  // ------------------------------
  // State and command register
  // ------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      command    <= '0;
      freeTop    <= '0;
      nextUnused <= '0;
      for (int i = 0; i < arrayCount; i++) begin
        allocated[i] <= 1'b0;
        sizes[i]     <= '0;
      end
    end else begin
      command <= nextCommand;
      if (requestValid) begin
        if (doReset) begin
          freeTop    <= '0;
          nextUnused <= '0;
          for (int i = 0; i < arrayCount; i++) begin
            allocated[i] <= 1'b0;
          end
        end
        if (doAlloc) begin
          allocated[allocId] <= 1'b1;
          if (fromStack) begin
            freeTop <= stackTop;                   // Pop the free stack
          end else begin
            nextUnused <= nextUnused + 1'b1;
          end
        end
        if (doFree) begin
          allocated[request.array] <= 1'b0;
          freeTop                  <= freeTop + 1'b1;
        end
        if (sizeWrite) begin
          sizes[sizeTarget] <= sizeValue;
        end
      end
    end
  end

  // Only allocated arrays can be freed, so the stack never overflows
  always_ff @(posedge clock) begin
    if (requestValid && doFree) begin
      freeStack[freeTop[arrayBits-1:0]] <= request.array;
    end
  end

endmodule

/* arrayMachine.sv */
/*
  Array memory engine top level. One request per cycle at most,
  response exactly pipeDepth cycles later, no back-pressure.
*/
`timescale 1ns/100ps

module arrayMachine import arrayPkg::*; (
  input  logic         clock,
  input  logic         resetN,
  input  logic         requestValid,
  input  arrayRequest  request,
  output logic         responseValid,
  output arrayResponse response
);

  storeCommand   command;                          // Stage 1 to stage 2
  storeCommand   stagedCommand;                    // Stage 2 to stage 3
  elementWord    storedValue;
  storeWriteback writeback;                        // Stage 3 back to memory

  // ------------------------------
  // Pipeline stages
  // ------------------------------
  arrayControl control (
    .clock        (clock),
    .resetN       (resetN),
    .requestValid (requestValid),
    .request      (request),
    .command      (command)
  );

  elementStore store (
    .clock         (clock),
    .resetN        (resetN),
    .command       (command),
    .writeback     (writeback),
    .stagedCommand (stagedCommand),
    .storedValue   (storedValue)
  );

  elementAlu alu (
    .clock         (clock),
    .resetN        (resetN),
    .stagedCommand (stagedCommand),
    .storedValue   (storedValue),
    .writeback     (writeback),
    .responseValid (responseValid),
    .response      (response)
  );

endmodule

/* arrayMachineTb.sv */
/*
  Testbench for the array memory engine. Requests come from a fixed seed and are
  checked against a reference model whose responses are queued for pipeDepth cycles.
  Writes never skip a slot, so every element inside an array's size is defined.
*/
`timescale 1ns/100ps

module arrayMachineTb import arrayPkg::*; ();

  typedef struct packed {
    logic         valid;
    arrayResponse response;
  } expectedEntry;

  logic         clock;
  logic         resetN;
  logic         requestValid;
  arrayRequest  request;
  logic         responseValid;
  arrayResponse response;

  integer       seed;
  int           checks;
  int           errors;
  expectedEntry expectQueue [$];                   // One entry per driven cycle

  // Reference model state
  logic         modelAllocated [arrayCount];
  int           modelSize      [arrayCount];
  elementWord   modelMemory    [arrayCount][arrayLength];
  int           modelFreeStack [$];
  int           modelNextUnused;

  arrayMachine dut0 (
    .clock         (clock),
    .resetN        (resetN),
    .requestValid  (requestValid),
    .request       (request),
    .responseValid (responseValid),
    .response      (response)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    #200000;
    $display("Timeout: the run did not reach its end in time");
    $display("TESTS FAILED");
    $finish;
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  task automatic modelStep(input arrayRequest r, output arrayResponse e);
    int         id;
    int         size;
    int         index;
    elementWord old;
    e     = '0;
    id    = int'(r.array);
    size  = modelSize[id];
    index = int'(r.index);
    old   = modelMemory[id][index];
    if (r.opcode == opReset) begin
      foreach (modelAllocated[i]) begin
        modelAllocated[i] = 1'b0;
      end
      modelFreeStack.delete();
      modelNextUnused = 0;
    end else if (r.opcode == opAlloc) begin
      if (modelFreeStack.size() > 0) begin
        id = modelFreeStack.pop_back();            // Most recently freed first
      end else if (modelNextUnused < arrayCount) begin
        id = modelNextUnused;
        modelNextUnused++;
      end else begin
        e.error = errOutOfMemory;
      end
      if (e.error == errNone) begin
        modelAllocated[id] = 1'b1;
        modelSize[id]      = 0;
        e.value            = elementWord'(id);
      end
    end else if (!modelAllocated[id]) begin
      e.error = errNotAllocated;
    end else begin
      case (r.opcode)
        opFree: begin
          modelAllocated[id] = 1'b0;
          modelFreeStack.push_back(id);
        end
        opWrite: begin
          modelMemory[id][index] = r.operand;
          if (index >= size)
            modelSize[id] = index + 1;
          e.value = r.operand;
        end
        opSize: begin
          e.value = elementWord'(size);
        end
        opPush: begin
          if (size == arrayLength) begin
            e.error = errFull;
          end else begin
            modelMemory[id][size] = r.operand;
            modelSize[id]         = size + 1;
            e.value               = r.operand;
          end
        end
        opPop: begin
          if (size == 0) begin
            e.error = errEmpty;
          end else begin
            modelSize[id] = size - 1;
            e.value       = modelMemory[id][size-1];
          end
        end
        default: begin                             // Read and element arithmetic
          if (index >= size) begin
            e.error = errOutOfBounds;
          end else begin
            case (r.opcode)
              opAdd, opAddAfter: modelMemory[id][index] = old + r.operand;
              opSubtract:        modelMemory[id][index] = old - r.operand;
              opXor:             modelMemory[id][index] = old ^ r.operand;
              default:           modelMemory[id][index] = old;
            endcase
            e.value = (r.opcode == opAddAfter) ? old : modelMemory[id][index];
          end
        end
      endcase
    end
  endtask

  // ------------------------------
  // Drive and check
  // ------------------------------
  task automatic checkResponse();
    expectedEntry x;
    x = '0;
    if (expectQueue.size() > pipeDepth)
      x = expectQueue.pop_front();
    checks++;
    assert (responseValid === x.valid) else begin
      errors++;
      $display("Fail responseValid: got %h, expected %h", responseValid, x.valid);
    end
    if (x.valid) begin
      assert (response.error === x.response.error) else begin
        errors++;
        $display("Fail response.error: got %h, expected %h", response.error,
                 x.response.error);
      end
      assert (response.value === x.response.value) else begin
        errors++;
        $display("Fail response.value: got %h, expected %h", response.value,
                 x.response.value);
      end
    end
  endtask

  task automatic step(input logic valid, input arrayRequest r);
    expectedEntry x;
    arrayResponse e;
    x = '0;
    @(posedge clock);
    if (valid) begin
      modelStep(r, e);
      x.valid    = 1'b1;
      x.response = e;
    end
    expectQueue.push_back(x);
    requestValid <= valid;
    request      <= r;
    @(negedge clock);                              // Outputs settled here
    checkResponse();
  endtask

  task automatic send(input arrayOpcode op, input int array, input int index,
                      input int operand);
    arrayRequest r;
    r.opcode  = op;
    r.array   = arrayId'(array);
    r.index   = elementIndex'(index);
    r.operand = elementWord'(operand);
    step(1'b1, r);
  endtask

  task automatic randomRequest();
    int         pick;
    int         array;
    int         index;
    arrayOpcode op;
    pick  = ($random(seed) & 32'h7fffffff) % 20;
    array = $random(seed) & 3;
    index = $random(seed) & 3;
    case (pick)
      0, 1, 2, 3: op = opAlloc;                    // Weighted so arrays get used
      4, 5, 6, 7: op = opWrite;
      8:          op = opFree;
      9, 10:      op = opRead;
      11:         op = opSize;
      12:         op = opPush;
      13:         op = opPop;
      14:         op = opAdd;
      15:         op = opAddAfter;
      16:         op = opSubtract;
      17:         op = opXor;
      default:    op = opReset;
    endcase
    if (op == opWrite && modelAllocated[array] && index > modelSize[array])
      index = modelSize[array];
    if (pick >= 18 && ($random(seed) & 7) != 0)
      step(1'b0, '0);                              // Idle cycle
    else
      send(op, array, index, $random(seed) & 12'hfff);
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    seed            = 32'hbecd546c;
    checks          = 0;
    errors          = 0;
    modelNextUnused = 0;
    resetN          = 1'b0;
    requestValid    = 1'b0;
    request         = '0;
    foreach (modelAllocated[i]) begin
      modelAllocated[i] = 1'b0;
      modelSize[i]      = 0;
    end
    repeat (5) @(posedge clock);
    resetN <= 1'b1;

    repeat (5) send(opAlloc, 0, 0, 0);             // Fifth one runs out
    send(opFree, 2, 0, 0);
    send(opAlloc, 0, 0, 0);

    send(opWrite, 0, 0, 'h123);
    send(opWrite, 0, 1, 'h456);
    send(opSize, 0, 0, 0);
    send(opRead, 0, 1, 0);
    send(opRead, 0, 2, 0);                         // At the size
    send(opFree, 3, 0, 0);
    send(opRead, 3, 0, 0);
    send(opFree, 3, 0, 0);

    for (int i = 0; i < 5; i++)
      send(opPush, 1, 0, 'h0a0 + i);
    for (int i = 0; i < 5; i++)
      send(opPop, 1, 0, 0);

    // One element every cycle, wrapping at 12 bits
    send(opWrite, 0, 0, 'hff0);
    send(opAdd, 0, 0, 'h020);
    send(opAddAfter, 0, 0, 'h7ff);
    send(opSubtract, 0, 0, 'hfff);
    send(opXor, 0, 0, 'h5a5);
    send(opRead, 0, 0, 0);
    send(opAdd, 0, 1, 1);
    step(1'b0, '0);
    send(opAdd, 0, 1, 1);
    step(1'b0, '0);
    step(1'b0, '0);
    send(opRead, 0, 1, 0);

    send(opReset, 0, 0, 0);
    send(opSize, 1, 0, 0);
    send(opAlloc, 0, 0, 0);

    repeat (400) randomRequest();

    // Last requests leave the pipeline
    repeat (pipeDepth) step(1'b0, '0);

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* arrayMachine_properties.sv */
/*
  Timing properties of the array memory engine, bound to its top level.
  Responses follow requests by exactly pipeDepth cycles.
*/
`timescale 1ns/100ps

module arrayMachineProperties import arrayPkg::*; (
  input logic clock,
  input logic resetN,
  input logic requestValid,
  input logic responseValid
);

  // Fixed latency, no back-pressure
  latencyHolds: assert property (
    @(posedge clock) disable iff (!resetN)
    responseValid == $past(requestValid, pipeDepth)
  ) else $error("responseValid does not follow requestValid by %0d cycles", pipeDepth);

  quietInReset: assert property (
    @(posedge clock) !resetN |-> !responseValid
  ) else $error("responseValid is high during reset");

endmodule

bind arrayMachine arrayMachineProperties props0 (
  .clock         (clock),
  .resetN        (resetN),
  .requestValid  (requestValid),
  .responseValid (responseValid)
);

/* arrayPkg.sv */
/*
  Sizes, opcodes, error codes and stage structs of the array memory engine.
  Four arrays of four 12-bit elements. Every request gets a response pipeDepth cycles later.
*/
package arrayPkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int arrayBits   = 2;                // Four arrays
  localparam int indexBits   = 2;                // Four elements per array
  localparam int dataBits    = 12;               // Element width
  localparam int arrayCount  = 1 << arrayBits;
  localparam int arrayLength = 1 << indexBits;
  localparam int pipeDepth   = 3;                // Request to response, in cycles

  typedef logic [arrayBits-1:0] arrayId;
  typedef logic [indexBits-1:0] elementIndex;
  typedef logic [indexBits:0]   sizeCount;       // Must reach arrayLength
  typedef logic [dataBits-1:0]  elementWord;

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [3:0] {
    opReset,
    opAlloc,
    opFree,
    opWrite,
    opRead,
    opSize,
    opPush,
    opPop,
    opAdd,
    opAddAfter,
    opSubtract,
    opXor
  } arrayOpcode;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory
  } arrayError;

  // New element value formed in stage 3
  typedef enum logic [2:0] {
    fnKeep,
    fnReplace,
    fnAdd,
    fnSubtract,
    fnXor
  } elementFunction;

  // ------------------------------
  // Stage structs
  // ------------------------------
  typedef struct packed {
    arrayId      array;
    elementIndex index;
  } elementAddress;

  typedef struct packed {
    arrayOpcode  opcode;
    arrayId      array;
    elementIndex index;
    elementWord  operand;
  } arrayRequest;

  typedef struct packed {
    logic           valid;
    elementAddress  address;
    elementFunction func;
    logic           writeEnable;
    logic           reportOld;                   // Report value before the update
    logic           direct;                      // Report directValue, memory not involved
    elementWord     directValue;
    elementWord     operand;
    arrayError      error;
  } storeCommand;

  typedef struct packed {
    logic          enable;
    elementAddress address;
    elementWord    value;
  } storeWriteback;

  typedef struct packed {
    arrayError  error;
    elementWord value;
  } arrayResponse;

endpackage

/* elementAlu.sv */
/*
  Stage 3. Forms the new element value, wrapping at 12 bits.
  The write-back is combinational and lands in memory on the next edge.
*/
`timescale 1ns/100ps

module elementAlu import arrayPkg::*; (
  input  logic          clock,
  input  logic          resetN,
  input  storeCommand   stagedCommand,
  input  elementWord    storedValue,
  output storeWriteback writeback,
  output logic          responseValid,
  output arrayResponse  response
);

  elementWord newValue;
  elementWord reportValue;

  // ------------------------------
  // Element function
  // ------------------------------
  always_comb begin
    case (stagedCommand.func)
      fnReplace:  newValue = stagedCommand.operand;
      fnAdd:      newValue = storedValue + stagedCommand.operand;
      fnSubtract: newValue = storedValue - stagedCommand.operand;
      fnXor:      newValue = storedValue ^ stagedCommand.operand;
      default:    newValue = storedValue;          // Keep
    endcase
  end

  // Errors already cleared writeEnable in stage 1
  assign writeback.enable  = stagedCommand.valid && stagedCommand.writeEnable;
  assign writeback.address = stagedCommand.address;
  assign writeback.value   = newValue;

  // ------------------------------
  // Response
  // ------------------------------
  always_comb begin
    if (stagedCommand.error != errNone) begin
      reportValue = '0;
    end else if (stagedCommand.direct) begin
      reportValue = stagedCommand.directValue;
    end else if (stagedCommand.reportOld) begin
      reportValue = storedValue;                   // AddAfter and Pop
    end else begin
      reportValue = newValue;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      responseValid <= 1'b0;
      response      <= '0;
    end else begin
      responseValid  <= stagedCommand.valid;
      response.error <= stagedCommand.error;
      response.value <= reportValue;
    end
  end

endmodule

/* elementStore.sv */
/*
  Stage 2. Element memory with a registered read.
  A write-back to the address read in the same cycle is forwarded.
*/
`timescale 1ns/100ps

module elementStore import arrayPkg::*; (
  input  logic          clock,
  input  logic          resetN,
  input  storeCommand   command,
  input  storeWriteback writeback,
  output storeCommand   stagedCommand,
  output elementWord    storedValue
);

  elementWord memory [arrayCount][arrayLength];
  elementWord readValue;
  logic       forward;

  // ------------------------------
  // Read with forwarding
  // ------------------------------
  always_comb begin
    forward   = writeback.enable && (writeback.address == command.address);
    readValue = forward ? writeback.value
                        : memory[command.address.array][command.address.index];
  end

  // Write-back from stage 3
  always_ff @(posedge clock) begin
    if (writeback.enable) begin
      memory[writeback.address.array][writeback.address.index] <= writeback.value;
    end
  end

  always_ff @(posedge clock) begin
    storedValue <= readValue;                      // Element seen by stage 3
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      stagedCommand <= '0;
    end else begin
      stagedCommand <= command;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the array memory engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module arrayMachineTb \
  -f src.f --Mdir obj_dir -o arrayMachineSim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/arrayMachineSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

/* src.f */
arrayPkg.sv
arrayControl.sv
elementStore.sv
elementAlu.sv
arrayMachine.sv
arrayMachine_properties.sv
arrayMachineTb.sv
